// ==== btb_config.svh ====
// ------------------------------
// Size settings of the branch target buffer
// BTB_LINES must stay 2**(BTB_ADDR_HI-3)
// Bit 3 picks the bank and bit 1 the way
// ------------------------------
`ifndef BTB_CONFIG_SVH
`define BTB_CONFIG_SVH

// Highest fetch address bit used for index, bank and offset
`define BTB_ADDR_HI 8

// Tag stored with each branch entry
`define BTB_TAG_W 6

// Offset from the fetch address to the branch target
`define BTB_TOFFSET_W 12

// Indexes per bank and way, from address bits BTB_ADDR_HI down to 4
`define BTB_LINES (1 << (`BTB_ADDR_HI - 3))

`endif

// ==== btb_pkg.sv ====
// ------------------------------
// Types shared by the branch target buffer
// Entry field order sets the storage layout
// ------------------------------
`default_nettype none

package btb_pkg;

`include "btb_config.svh"

   // ------------------------------
   // Address and field vectors
   // ------------------------------

   // Halfword fetch address
   typedef logic [`BTB_ADDR_HI:1] btb_addr_t;

   // Line index, one per storage row
   typedef logic [`BTB_ADDR_HI:4] btb_index_t;

   typedef logic [`BTB_TAG_W-1:0] btb_tag_t;

   typedef logic [`BTB_TOFFSET_W-1:0] btb_toffset_t;

   // ------------------------------
   // Entry and response
   // ------------------------------

   // One predicted branch, tag in the top bits
   typedef struct packed {
      btb_tag_t     tag;
      btb_toffset_t toffset;
      logic         pc4;
      logic         boff;
      logic [1:0]   hist;
      logic         valid;
   } btb_entry_t;

   // Four half-bank slots, or four positions in fetch order
   typedef btb_entry_t [3:0] btb_slot_vec_t;

   // Read result in fetch order
   typedef struct packed {
      logic [3:0]    hit;
      btb_slot_vec_t entry;
   } btb_rd_resp_t;

endpackage

`default_nettype wire

// ==== btb_sram.sv ====
// ------------------------------
// Single-port array, registered read
// Read data holds when re is low
// A write is not seen by a read in the same cycle
// ------------------------------
`default_nettype none

module btb_sram #(
   parameter int DEPTH = 32,
   parameter int WIDTH = 8
) (
   input  wire logic                     clk,
   input  wire logic                     we,
   input  wire logic                     re,
   input  wire logic [$clog2(DEPTH)-1:0] addr,
   input  wire logic [WIDTH-1:0]         wdata,
   output logic      [WIDTH-1:0]         rdata
);

   logic [WIDTH-1:0] mem [DEPTH];

   // Write port
   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= wdata;
      end
   end

   // Read port, old contents on a shared address
   always_ff @(posedge clk) begin
      if (re) begin
         rdata <= mem[addr];
      end
   end

endmodule

`default_nettype wire

// ==== btb_storage.sv ====
// ------------------------------
// Entry arrays, two banks by two ways
// Only validating writes reach the arrays
// rden and wren must not be high together
// ------------------------------
`default_nettype none

`include "btb_config.svh"

module btb_storage
   import btb_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       rden,
   input  wire logic       wren,
   input  wire btb_addr_t  rw_addr,
   input  wire btb_entry_t wr_entry,
   output btb_entry_t [1:0][1:0] rd_entry_f1
);

   btb_index_t      rw_index;
   logic [1:0][1:0] wr_en;

   // Index shared by read and write
   assign rw_index = rw_addr[`BTB_ADDR_HI:4];

   // ------------------------------
   // Write decode
   // ------------------------------

   // Bit 3 is the bank, bit 1 the way; bit 2 plays no part here
   always_comb begin
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < 2; w++) begin
            wr_en[b][w] = wren & wr_entry.valid &
                          (rw_addr[3] == 1'(b)) & (rw_addr[1] == 1'(w));
         end
      end
   end

   // ------------------------------
   // Arrays
   // ------------------------------

   for (genvar b = 0; b < 2; b++) begin : g_bank
      for (genvar w = 0; w < 2; w++) begin : g_way
         btb_sram #(
            .DEPTH (`BTB_LINES),
            .WIDTH ($bits(btb_entry_t))
         ) sram_i (
            .clk   (clk),
            .we    (wr_en[b][w]),
            .re    (rden),
            .addr  (rw_index),
            .wdata (wr_entry),
            .rdata (rd_entry_f1[b][w])
         );
      end
   end

   // Single port, a read and a write never share a cycle
   a_rw_exclusive : assert property (
      @(posedge clk) disable iff (rst) !(rden && wren)
   ) else $error("btb_storage: rden and wren high in the same cycle");

endmodule

`default_nettype wire

// ==== btb_valid_array.sv ====
// ------------------------------
// Valid bits and F1 request registers
// All bits clear on reset
// A write updates its bit one cycle late
// ------------------------------
`default_nettype none

`include "btb_config.svh"

module btb_valid_array
   import btb_pkg::*;
(
   input  wire logic      clk,
   input  wire logic      rst,
   input  wire logic      rden,
   input  wire logic      wren,
   input  wire btb_addr_t rw_addr,
   input  wire logic      wr_valid,
   output logic           rd_req_f1,
   output logic [1:0]     fetch_start_f1,
   output logic [3:0]     rd_valid_f1
);

   logic       wren_f1;
   logic       wr_valid_f1;
   btb_addr_t  addr_f1;
   btb_index_t index_f1;

   // Per index, bank and way
   logic [`BTB_LINES-1:0][1:0][1:0] valid_q;

   // ------------------------------
   // F1 request registers
   // ------------------------------

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_req_f1 <= 1'b0;
         wren_f1   <= 1'b0;
      end else begin
         rd_req_f1 <= rden;
         wren_f1   <= wren;
      end
   end

   // Address and write data follow the strobes
   always_ff @(posedge clk) begin
      addr_f1     <= rw_addr;
      wr_valid_f1 <= wr_valid;
   end

   assign index_f1       = addr_f1[`BTB_ADDR_HI:4];
   assign fetch_start_f1 = addr_f1[3:2];

   // ------------------------------
   // Valid bit update
   // ------------------------------

   // Set on a validating write, clear on an invalidating one
   always_ff @(posedge clk) begin
      if (rst) begin
         valid_q <= '0;
      end else if (wren_f1) begin
         valid_q[index_f1][addr_f1[3]][addr_f1[1]] <= wr_valid_f1;
      end
   end

   // Bit 2*bank+way of the four at the read index
   assign rd_valid_f1 = {4{rd_req_f1}} & valid_q[index_f1];

   // An F1 read right after an invalidate sees the cleared bit
   a_invalidate_clears : assert property (
      @(posedge clk) disable iff (rst)
      (wren_f1 && !wr_valid_f1) |=>
         (index_f1 != $past(index_f1)) ||
         !rd_valid_f1[{$past(addr_f1[3]), $past(addr_f1[1])}]
   ) else $error("btb_valid_array: valid bit still set after invalidate");

endmodule

`default_nettype wire

// ==== btb_hit_select.sv ====
// ------------------------------
// Tag compare and fetch-order reorder
// Purely combinational, F1 cycle
// Slots past the line end return empty
// ------------------------------
`default_nettype none

module btb_hit_select
   import btb_pkg::*;
(
   input  wire logic       rd_req_f1,
   input  wire logic [1:0] fetch_start_f1,
   input  wire logic [3:0] rd_valid_f1,
   input  wire btb_entry_t [1:0][1:0] rd_entry_f1,
   input  wire btb_tag_t   rd_tag_f1,
   output btb_rd_resp_t    rd_resp
);

   logic [3:0]    slot_hit;
   btb_slot_vec_t slot_entry;

   // ------------------------------
   // Compare and slot expansion
   // ------------------------------

   // Each match lands in the even or odd half of its bank
   always_comb begin : p_slots
      btb_entry_t cur;
      logic       match;
      logic [1:0] slot;

      slot_hit   = '0;
      slot_entry = '0;
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < 2; w++) begin
            cur       = rd_entry_f1[b][w];
            // Stored valid field is replaced by the valid array bit
            cur.valid = rd_valid_f1[2*b+w];
            match     = cur.valid & (cur.tag == rd_tag_f1);
            slot      = {1'(b), cur.boff ^ cur.pc4};
            if (match) begin
               slot_hit[slot]   = 1'b1;
               // Both ways in one slot merge by OR
               slot_entry[slot] = slot_entry[slot] | cur;
            end
         end
      end
   end

   // ------------------------------
   // Rotation into fetch order
   // ------------------------------

   always_comb begin : p_rotate
      logic [2:0] src;

      rd_resp = '0;
      for (int n = 0; n < 4; n++) begin
         src = {1'b0, fetch_start_f1} + 3'(n);
         // No next line, so anything past slot 3 stays empty
         if (!src[2]) begin
            rd_resp.hit[n]   = slot_hit[src[1:0]];
            rd_resp.entry[n] = slot_entry[src[1:0]];
         end
      end
   end

   // Hits only ever come from a requested read
   always_comb begin
      a_hit_needs_req : assert final (rd_req_f1 || (rd_resp.hit == 4'b0000))
         else $error("btb_hit_select: hit reported without a read request");
   end

endmodule

`default_nettype wire

// ==== btb_top.sv ====
// ------------------------------
// Branch target buffer storage, top level
// One-cycle read, hits valid in F1
// Never read and write in one cycle
// ------------------------------
`default_nettype none

module btb_top
   import btb_pkg::*;
(
   input  wire logic       clk,
   input  wire logic       rst,
   input  wire logic       rden,
   input  wire logic       wren,
   input  wire btb_addr_t  rw_addr,
   input  wire btb_entry_t wr_entry,
   input  wire btb_tag_t   rd_tag_f1,
   output btb_rd_resp_t    rd_resp
);

   logic                  rd_req_f1;
   logic [1:0]            fetch_start_f1;
   logic [3:0]            rd_valid_f1;
   btb_entry_t [1:0][1:0] rd_entry_f1;

   // Entry arrays
   btb_storage storage_i (
      .clk         (clk),
      .rst         (rst),
      .rden        (rden),
      .wren        (wren),
      .rw_addr     (rw_addr),
      .wr_entry    (wr_entry),
      .rd_entry_f1 (rd_entry_f1)
   );

   // Valid bits and F1 request
   btb_valid_array valid_i (
      .clk            (clk),
      .rst            (rst),
      .rden           (rden),
      .wren           (wren),
      .rw_addr        (rw_addr),
      .wr_valid       (wr_entry.valid),
      .rd_req_f1      (rd_req_f1),
      .fetch_start_f1 (fetch_start_f1),
      .rd_valid_f1    (rd_valid_f1)
   );

   // F1 compare and reorder
   btb_hit_select hit_i (
      .rd_req_f1      (rd_req_f1),
      .fetch_start_f1 (fetch_start_f1),
      .rd_valid_f1    (rd_valid_f1),
      .rd_entry_f1    (rd_entry_f1),
      .rd_tag_f1      (rd_tag_f1),
      .rd_resp        (rd_resp)
   );

endmodule

`default_nettype wire

// ==== tb_btb_model.svh ====
// ------------------------------
// Reference model of the BTB storage
// Included inside tb_btb_top, uses its counters
// Both ways in one slot merge by OR
// ------------------------------
`ifndef TB_BTB_MODEL_SVH
`define TB_BTB_MODEL_SVH

btb_entry_t model_entry [`BTB_LINES][2][2];
bit         model_valid [`BTB_LINES][2][2];

// Validating writes store the entry, invalidating ones clear the bit only
function automatic void model_write(btb_addr_t addr, btb_entry_t entry);
   btb_index_t idx;

   idx = addr[`BTB_ADDR_HI:4];
   model_valid[idx][addr[3]][addr[1]] = entry.valid;
   if (entry.valid) begin
      model_entry[idx][addr[3]][addr[1]] = entry;
   end
endfunction

// Expected response for a read at idx with fetch start and F1 tag
function automatic btb_rd_resp_t predict(btb_index_t idx, logic [1:0] start,
                                         btb_tag_t tag);
   btb_rd_resp_t  resp;
   btb_slot_vec_t slots;
   btb_entry_t    e;
   logic [3:0]    hit;
   int            slot;
   int            pos;

   resp  = '0;
   slots = '0;
   hit   = '0;
   for (int b = 0; b < 2; b++) begin
      for (int w = 0; w < 2; w++) begin
         e = model_entry[idx][b][w];
         if (model_valid[idx][b][w] && e.tag == tag) begin
            slot        = 2 * b + (e.boff ^ e.pc4);
            hit[slot]   = 1'b1;
            slots[slot] = slots[slot] | e;
         end
      end
   end
   // Fetch order, nothing past the line end
   for (int n = 0; n < 4; n++) begin
      pos = int'(start) + n;
      if (pos < 4) begin
         resp.hit[n]   = hit[pos];
         resp.entry[n] = slots[pos];
      end
   end
   return resp;
endfunction

task automatic check_resp(string name, btb_rd_resp_t exp, btb_rd_resp_t act);
   num_checks++;
   if (act !== exp) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_with_failure({name, " differs from the model"});
   end
endtask

task automatic check_hit(string name, logic [3:0] exp, logic [3:0] act);
   num_checks++;
   if (act !== exp) begin
      $display("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_with_failure({name, " has the wrong hit pattern"});
   end
endtask

`endif

// ==== tb_btb_top.sv ====
// ------------------------------
// Directed testbench for btb_top
// Inputs change 1 ns after the rising edge
// Responses are sampled at the falling edge
// ------------------------------
`default_nettype none

`include "btb_config.svh"

module tb_btb_top
   import btb_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int SETS  = 6;
   localparam int READS = 12;
   // Reset, tests 1 to 4, then the write sets and the read burst
   localparam int RUN_CYCLES = 4 + 6 + 10 + 6 + 6 + SETS * 8 + READS + 4;
   localparam int TIMEOUT_NS = RUN_CYCLES * 4 + 200;

   logic         clk;
   logic         rst;
   logic         rden;
   logic         wren;
   btb_addr_t    rw_addr;
   btb_entry_t   wr_entry;
   btb_tag_t     rd_tag_f1;
   btb_rd_resp_t rd_resp;

   integer seed       = 10465;
   int     num_checks = 0;

   `include "tb_btb_model.svh"

   btb_top dut_i (
      .clk       (clk),
      .rst       (rst),
      .rden      (rden),
      .wren      (wren),
      .rw_addr   (rw_addr),
      .wr_entry  (wr_entry),
      .rd_tag_f1 (rd_tag_f1),
      .rd_resp   (rd_resp)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   task automatic stop_with_failure(string why);
      $display("Simulation FAILED");
      $fatal(1, "%s", why);
   endtask

   initial begin : watchdog
      #(TIMEOUT_NS);
      stop_with_failure($sformatf("run timed out, tests not done after %0d ns", TIMEOUT_NS));
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   function automatic btb_addr_t addr_of(btb_index_t idx, logic [1:0] mid, logic low);
      return {idx, mid, low};
   endfunction

   // Slot inside the bank is odd when boff differs from pc4
   function automatic btb_entry_t make_entry(btb_tag_t tag, logic odd);
      btb_entry_t e;

      e.tag     = tag;
      e.toffset = btb_toffset_t'($random(seed));
      e.pc4     = 1'($random(seed));
      e.boff    = e.pc4 ^ odd;
      e.hist    = 2'($random(seed));
      e.valid   = 1'b1;
      return e;
   endfunction

   // One write cycle, then the bus stays idle for a cycle
   task automatic write_entry(btb_addr_t addr, btb_entry_t entry);
      next_cycle();
      wren     = 1'b1;
      rw_addr  = addr;
      wr_entry = entry;
      model_write(addr, entry);
      next_cycle();
      wren = 1'b0;
   endtask

   task automatic read_and_check(btb_index_t idx, logic [1:0] start, btb_tag_t tag,
                                 logic [3:0] exp_hit);
      next_cycle();
      rden    = 1'b1;
      rw_addr = addr_of(idx, start, 1'b0);
      next_cycle();
      rden      = 1'b0;
      rd_tag_f1 = tag;
      @(negedge clk);
      check_resp("rd_resp", predict(idx, start, tag), rd_resp);
      check_hit("rd_resp.hit", exp_hit, rd_resp.hit);
   endtask

   // ------------------------------
   // Directed tests
   // ------------------------------

   task automatic test_reset_empty();
      read_and_check(btb_index_t'(0), 2'd0, 6'h00, 4'b0000);
      read_and_check(btb_index_t'(7), 2'd2, 6'h15, 4'b0000);
      read_and_check(btb_index_t'(31), 2'd3, 6'h3f, 4'b0000);
   endtask

   // Bank 1 takes the reversed odd pattern so all four slots fill
   task automatic test_write_read();
      for (int b = 0; b < 2; b++) begin
         for (int w = 0; w < 2; w++) begin
            write_entry(addr_of(btb_index_t'(5), {1'(b), 1'b0}, 1'(w)),
                        make_entry(6'h2a, 1'(b ^ w)));
         end
      end
      read_and_check(btb_index_t'(5), 2'd0, 6'h2a, 4'b1111);
   endtask

   task automatic test_fetch_start();
      for (int s = 1; s < 4; s++) begin
         read_and_check(btb_index_t'(5), 2'(s), 6'h2a, 4'b1111 >> s);
      end
   endtask

   // Bank 1 way 0 sits in slot 3
   task automatic test_tag_mismatch_invalidate();
      read_and_check(btb_index_t'(5), 2'd0, 6'h2b, 4'b0000);
      write_entry(addr_of(btb_index_t'(5), 2'b10, 1'b0), '0);
      read_and_check(btb_index_t'(5), 2'd0, 6'h2a, 4'b0111);
   endtask

   task automatic test_back_to_back();
      btb_index_t set_idx [SETS];
      btb_tag_t   set_tag [SETS];
      btb_index_t rd_idx [READS];
      btb_tag_t   rd_tag [READS];
      logic [1:0] rd_start [READS];
      logic [1:0] flip;
      int         k;

      for (int i = 0; i < SETS; i++) begin
         set_idx[i] = btb_index_t'($random(seed));
         set_tag[i] = btb_tag_t'($random(seed));
         flip       = 2'($random(seed));
         for (int b = 0; b < 2; b++) begin
            for (int w = 0; w < 2; w++) begin
               write_entry(addr_of(set_idx[i], {1'(b), 1'b0}, 1'(w)),
                           make_entry(set_tag[i], 1'(w) ^ flip[b]));
            end
         end
      end
      for (int i = 0; i < READS; i++) begin
         k           = {$random(seed)} % SETS;
         rd_idx[i]   = set_idx[k];
         rd_tag[i]   = set_tag[k];
         rd_start[i] = 2'($random(seed));
      end
      // Each F1 cycle carries the tag of one read and the address of the next
      next_cycle();
      rden    = 1'b1;
      rw_addr = addr_of(rd_idx[0], rd_start[0], 1'b0);
      for (int i = 1; i <= READS; i++) begin
         next_cycle();
         rd_tag_f1 = rd_tag[i-1];
         if (i < READS) begin
            rw_addr = addr_of(rd_idx[i], rd_start[i], 1'b0);
         end else begin
            rden = 1'b0;
         end
         @(negedge clk);
         check_resp("rd_resp", predict(rd_idx[i-1], rd_start[i-1], rd_tag[i-1]), rd_resp);
      end
   endtask

   initial begin : main
      rst       = 1'b1;
      rden      = 1'b0;
      wren      = 1'b0;
      rw_addr   = '0;
      wr_entry  = '0;
      rd_tag_f1 = '0;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;

      test_reset_empty();
      test_write_read();
      test_fetch_start();
      test_tag_mismatch_invalidate();
      test_back_to_back();
      next_cycle();

      if (num_checks > 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         stop_with_failure("no checks were run");
      end
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
btb_pkg.sv
btb_sram.sv
btb_storage.sv
btb_valid_array.sv
btb_hit_select.sv
btb_top.sv
tb_btb_top.sv
